// ==== huff_tree_builder.f ====
+incdir+rtl
rtl/huff_pkg.sv
rtl/huff_histogram.sv
rtl/huff_find_least.sv
rtl/huff_node_store.sv
rtl/huff_tree_ctrl.sv
rtl/huff_tree_builder.sv
tests/huff_tree_builder_tb.sv

// ==== Bender.yml ====
package:
  name: huff_tree_builder

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/huff_pkg.sv
      - rtl/huff_histogram.sv
      - rtl/huff_find_least.sv
      - rtl/huff_node_store.sv
      - rtl/huff_tree_ctrl.sv
      - rtl/huff_tree_builder.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/huff_tree_builder_tb.sv

// ==== tests/huff_tree_builder_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "huff_defines.svh"

module huff_tree_builder_tb import huff_pkg::*; ();

    localparam int NROWS      = 7;
    localparam int MAXP       = 256;
    localparam int DONE_LIMIT = 60000;  // covers 130 merges of 386 cycles each.

    logic       clk;
    logic       rst;
    logic       byte_valid;
    logic [7:0] byte_data;
    logic       build_start;
    logic [6:0] node_rd_addr;
    logic       done;
    logic       build_overflow;
    node_id_t   root;
    huff_cnt_t  root_weight;
    logic [7:0] node_count;
    tree_node_t node_rd;

    // stimulus table, one row per case.
    int         row_start [NROWS];
    int         row_len   [NROWS];
    bit         row_ovf   [NROWS];
    logic [7:0] pair_byte [MAXP];
    int         pair_rep  [MAXP];
    int         npairs;
    int         cur_row;

    // software tree.
    huff_cnt_t  m_hist  [`HUFF_SYMBOLS];
    huff_cnt_t  m_w     [`HUFF_NODES];
    bit         m_live  [`HUFF_NODES];
    node_id_t   m_left  [`HUFF_NODES];
    node_id_t   m_right [`HUFF_NODES];
    int         m_count;
    node_id_t   m_root;
    huff_cnt_t  m_root_w;

    integer     seed;
    int         errors;
    int         checks;
    bit         timed_out;

    huff_tree_builder dut (
        .clk            (clk),
        .rst            (rst),
        .byte_valid     (byte_valid),
        .byte_data      (byte_data),
        .build_start    (build_start),
        .node_rd_addr   (node_rd_addr),
        .done           (done),
        .build_overflow (build_overflow),
        .root           (root),
        .root_weight    (root_weight),
        .node_count     (node_count),
        .node_rd        (node_rd)
    );

    always #4 clk = ~clk;

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic open_row(input bit ovf);
        cur_row++;
        row_start[cur_row] = npairs;
        row_len[cur_row]   = 0;
        row_ovf[cur_row]   = ovf;
    endtask

    task automatic add_pair(input logic [7:0] b, input int rep);
        pair_byte[npairs] = b;
        pair_rep[npairs]  = rep;
        npairs++;
        row_len[cur_row]++;
    endtask

    task automatic load_table();
        logic [31:0] rnd;
        logic [31:0] rep;
        npairs  = 0;
        cur_row = -1;
        open_row(1'b0);  // skewed.
        add_pair(8'h41, 40);
        add_pair(8'h42, 20);
        add_pair(8'h43, 10);
        add_pair(8'h44, 5);
        add_pair(8'h45, 2);
        add_pair(8'h46, 1);
        open_row(1'b0);  // ties between leaves and between leaves and nodes.
        add_pair(8'h10, 2);
        add_pair(8'h20, 2);
        add_pair(8'h30, 4);
        add_pair(8'h40, 4);
        add_pair(8'h05, 2);
        add_pair(8'h60, 8);
        open_row(1'b0);  // single symbol.
        add_pair(8'h7f, 9);
        open_row(1'b0);  // empty.
        open_row(1'b0);
        for (int i = 0; i < 20; i++) begin
            rnd = $random(seed);
            rep = $random(seed);
            add_pair(rnd[7:0], int'(rep[3:0]) + 1);
        end
        open_row(1'b1);  // more symbols than node slots.
        for (int i = 0; i < 140; i++) begin
            add_pair(8'(i), (i % 3) + 1);
        end
        open_row(1'b0);  // skewed again, after the overflow.
        for (int i = 0; i < row_len[0]; i++) begin
            add_pair(pair_byte[i], pair_rep[i]);
        end
    endtask

    function automatic huff_cnt_t scan_value(input int idx);
        if (idx < `HUFF_SYMBOLS) begin
            return m_hist[idx];
        end
        return m_live[idx - `HUFF_SYMBOLS] ? m_w[idx - `HUFF_SYMBOLS] : '0;
    endfunction

    function automatic node_id_t id_of(input int idx);
        node_id_t id;
        id.is_node = (idx >= `HUFF_SYMBOLS);
        id.index   = id.is_node ? 8'(idx - `HUFF_SYMBOLS) : 8'(idx);
        return id;
    endfunction

    // lightest live entry, earliest scan position on a tie.
    function automatic int lightest(input int skip);
        int best;
        best = -1;
        for (int idx = 0; idx < `HUFF_SYMBOLS + `HUFF_NODES; idx++) begin
            if (idx != skip && scan_value(idx) != '0 &&
                (best < 0 || scan_value(idx) < scan_value(best))) begin
                best = idx;
            end
        end
        return best;
    endfunction

    task automatic drop_entry(input int idx);
        if (idx < `HUFF_SYMBOLS) begin
            m_hist[idx] = '0;
        end else begin
            m_live[idx - `HUFF_SYMBOLS] = 1'b0;
        end
    endtask

    task automatic build_model(input int row);
        int a;
        int b;
        bit finished;
        for (int i = 0; i < `HUFF_SYMBOLS; i++) begin
            m_hist[i] = '0;
        end
        for (int i = 0; i < `HUFF_NODES; i++) begin
            m_w[i]    = '0;
            m_live[i] = 1'b0;
        end
        for (int p = row_start[row]; p < row_start[row] + row_len[row]; p++) begin
            m_hist[pair_byte[p]] += pair_rep[p];
        end
        m_count  = 0;
        m_root   = '0;
        m_root_w = '0;
        finished = 1'b0;
        while (!finished) begin
            a = lightest(-1);
            b = (a < 0) ? -1 : lightest(a);
            if (b < 0) begin
                if (a >= 0) begin
                    m_root   = id_of(a);
                    m_root_w = scan_value(a);
                end
                finished = 1'b1;
            end else if (m_count == `HUFF_NODES) begin
                finished = 1'b1;  // the DUT stops here with overflow.
            end else begin
                m_left[m_count]  = id_of(a);
                m_right[m_count] = id_of(b);
                m_w[m_count]     = scan_value(a) + scan_value(b);
                drop_entry(a);
                drop_entry(b);
                m_live[m_count] = 1'b1;
                m_count++;
            end
        end
    endtask

    task automatic wait_done(output bit ok);
        int n;
        n = 0;
        while (!done && n < DONE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        ok = done;
    endtask

    task automatic run_case(input int row);
        bit  ok;
        int  distinct;
        int  total;
        bit  seen [`HUFF_SYMBOLS];
        distinct = 0;
        total    = 0;
        for (int i = 0; i < `HUFF_SYMBOLS; i++) begin
            seen[i] = 1'b0;
        end
        for (int p = row_start[row]; p < row_start[row] + row_len[row]; p++) begin
            total += pair_rep[p];
            if (!seen[pair_byte[p]]) begin
                distinct++;
            end
            seen[pair_byte[p]] = 1'b1;
            for (int r = 0; r < pair_rep[p]; r++) begin
                @(negedge clk);
                byte_valid = 1'b1;
                byte_data  = pair_byte[p];
            end
        end
        build_model(row);
        @(negedge clk);
        byte_valid  = 1'b0;
        build_start = 1'b1;
        @(negedge clk);
        build_start = 1'b0;
        wait_done(ok);
        if (!ok) begin
            errors++;
            timed_out = 1'b1;
            $display("case %0d: done did not rise within %0d cycles", row, DONE_LIMIT);
        end else begin
            compare_value("build_overflow", build_overflow, row_ovf[row]);
            compare_value("node_count", node_count,
                          row_ovf[row] ? `HUFF_NODES : (distinct == 0 ? 0 : distinct - 1));
            compare_value("root", root, m_root);
            compare_value("root_weight", root_weight, m_root_w);
            if (!row_ovf[row]) begin
                compare_value("root_weight total", root_weight, total);
            end
            if (distinct == 1) begin
                compare_value("root leaf", root, {1'b0, pair_byte[row_start[row]]});
            end
            for (int k = 0; k < m_count; k++) begin
                @(negedge clk);
                node_rd_addr = 7'(k);
                @(posedge clk);
                compare_value($sformatf("node[%0d].left", k), node_rd.left, m_left[k]);
                compare_value($sformatf("node[%0d].right", k), node_rd.right, m_right[k]);
                compare_value($sformatf("node[%0d].weight", k), node_rd.weight, m_w[k]);
            end
            @(negedge clk);
            build_start = 1'b1;  // leave done and wipe the tree.
            @(negedge clk);
            build_start = 1'b0;
            compare_value("done after clear", done, 1'b0);
            compare_value("node_count after clear", node_count, 0);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        byte_valid   = 1'b0;
        byte_data    = '0;
        build_start  = 1'b0;
        node_rd_addr = '0;
        seed         = 38;
        errors       = 0;
        checks       = 0;
        timed_out    = 1'b0;
        load_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int row = 0; row < NROWS && !timed_out; row++) begin
            run_case(row);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/huff_tree_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

module huff_tree_builder import huff_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         byte_valid,
    input  wire [7:0]   byte_data,
    input  wire         build_start,
    input  wire [6:0]   node_rd_addr,
    output logic        done,
    output logic        build_overflow,
    output node_id_t    root,
    output huff_cnt_t   root_weight,
    output logic [7:0]  node_count,
    output tree_node_t  node_rd
);

    logic        count_en;
    logic        scan_en;
    logic        merge_we;
    logic        clear;
    logic        scan_fin;
    logic [7:0]  leaf_addr;
    logic [6:0]  node_addr;
    huff_cnt_t   leaf_count;
    huff_cnt_t   node_weight;
    least_pair_t least;

    huff_histogram u_histogram (
        .clk        (clk),
        .rst        (rst),
        .clear      (clear),
        .count_en   (count_en),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .leaf_addr  (leaf_addr),
        .wipe_en    (merge_we),
        .wipe_a     (least.first),
        .wipe_b     (least.second),
        .leaf_count (leaf_count)
    );

    huff_find_least u_find_least (
        .clk         (clk),
        .rst         (rst),
        .scan_en     (scan_en),
        .leaf_count  (leaf_count),
        .node_weight (node_weight),
        .leaf_addr   (leaf_addr),
        .node_addr   (node_addr),
        .least       (least),
        .scan_fin    (scan_fin)
    );

    huff_node_store u_node_store (
        .clk         (clk),
        .rst         (rst),
        .clear       (clear),
        .merge_we    (merge_we),
        .least       (least),
        .node_addr   (node_addr),
        .rd_addr     (node_rd_addr),
        .node_weight (node_weight),
        .rd_node     (node_rd),
        .node_count  (node_count)
    );

    huff_tree_ctrl u_tree_ctrl (
        .clk            (clk),
        .rst            (rst),
        .build_start    (build_start),
        .scan_fin       (scan_fin),
        .least          (least),
        .node_count     (node_count),
        .count_en       (count_en),
        .scan_en        (scan_en),
        .merge_we       (merge_we),
        .clear          (clear),
        .done           (done),
        .build_overflow (build_overflow),
        .root           (root),
        .root_weight    (root_weight)
    );

endmodule

`default_nettype wire

// ==== rtl/huff_tree_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "huff_defines.svh"

module huff_tree_ctrl import huff_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire               build_start,
    input  wire               scan_fin,
    input  wire least_pair_t  least,
    input  wire [7:0]         node_count,
    output logic              count_en,
    output logic              scan_en,
    output logic              merge_we,
    output logic              clear,
    output logic              done,
    output logic              build_overflow,
    output node_id_t          root,
    output huff_cnt_t         root_weight
);

    build_state_e state;
    build_state_e state_n;
    logic         last_scan;  // at most one live entry left.
    logic         full;

    assign last_scan = scan_fin && (least.second_val == CNT_NONE);
    assign full      = (node_count == `HUFF_NODES);

    always_comb begin
        state_n = state;
        case (state)
            ST_IDLE: begin
                if (build_start) begin
                    state_n = ST_SCAN;
                end
            end
            ST_SCAN: begin
                if (last_scan || (scan_fin && full)) begin
                    state_n = ST_DONE;
                end else if (scan_fin) begin
                    state_n = ST_MERGE;
                end
            end
            ST_MERGE: state_n = ST_SCAN;  // one cycle only.
            ST_DONE: begin
                if (build_start) begin
                    state_n = ST_IDLE;
                end
            end
            default: state_n = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= ST_IDLE;
            build_overflow <= 1'b0;
            root           <= '0;
            root_weight    <= '0;
        end else begin
            state <= state_n;
            if (clear) begin
                build_overflow <= 1'b0;
                root           <= '0;
                root_weight    <= '0;
            end else if (last_scan) begin
                root <= least.first;
                // an empty histogram leaves first at the sentinel.
                root_weight <= (least.first_val == CNT_NONE) ? '0 : least.first_val;
            end else if (scan_fin && full) begin
                build_overflow <= 1'b1;
            end
        end
    end

    assign count_en = (state == ST_IDLE);
    assign scan_en  = (state == ST_SCAN);
    assign merge_we = (state == ST_MERGE);
    assign done     = (state == ST_DONE);
    assign clear    = done && build_start;  // wipe the tree on the way back to idle.

endmodule

`default_nettype wire

// ==== rtl/huff_node_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "huff_defines.svh"

module huff_node_store import huff_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire               clear,
    input  wire               merge_we,
    input  wire least_pair_t  least,
    input  wire [6:0]         node_addr,
    input  wire [6:0]         rd_addr,
    output huff_cnt_t         node_weight,
    output tree_node_t        rd_node,
    output logic [7:0]        node_count
);

    node_id_t               left_id  [`HUFF_NODES];
    node_id_t               right_id [`HUFF_NODES];
    huff_cnt_t              weight   [`HUFF_NODES];
    logic [`HUFF_NODES-1:0] live;       // node not yet merged into a parent.
    logic [6:0]             wr_slot;

    assign wr_slot = node_count[6:0];

    always_ff @(posedge clk) begin
        if (merge_we) begin
            left_id[wr_slot]  <= least.first;
            right_id[wr_slot] <= least.second;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            node_count <= '0;
            live       <= '0;
            for (int i = 0; i < `HUFF_NODES; i++) begin
                weight[i] <= '0;
            end
        end else if (clear) begin
            node_count <= '0;
            live       <= '0;
            for (int i = 0; i < `HUFF_NODES; i++) begin
                weight[i] <= '0;
            end
        end else if (merge_we) begin
            if (least.first.is_node) begin
                live[least.first.index[6:0]] <= 1'b0;
            end
            if (least.second.is_node) begin
                live[least.second.index[6:0]] <= 1'b0;
            end
            live[wr_slot]   <= 1'b1;  // the new slot is never one of its own children.
            weight[wr_slot] <= least.sum;
            node_count      <= node_count + 8'd1;
        end
    end

    // consumed nodes read as zero to the finder, their weight stays for the reader.
    assign node_weight = live[node_addr] ? weight[node_addr] : '0;

    always_comb begin
        rd_node.left   = left_id[rd_addr];
        rd_node.right  = right_id[rd_addr];
        rd_node.weight = weight[rd_addr];
    end

    assert property (@(posedge clk) disable iff (rst)
        merge_we |-> (node_count != `HUFF_NODES))
        else $error("merge into a full node store");

endmodule

`default_nettype wire

// ==== rtl/huff_find_least.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "huff_defines.svh"

module huff_find_least import huff_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire             scan_en,
    input  wire huff_cnt_t  leaf_count,
    input  wire huff_cnt_t  node_weight,
    output logic [7:0]      leaf_addr,
    output logic [6:0]      node_addr,
    output least_pair_t     least,
    output logic            scan_fin
);

    logic [8:0]  scan_idx;
    node_id_t    id1;
    node_id_t    id2;
    huff_cnt_t   val1;
    huff_cnt_t   val2;
    node_id_t    cand_id;
    huff_cnt_t   cand_val;
    least_pair_t live;
    least_pair_t held;

    // indices 256..383 map onto node slots 0..127.
    assign leaf_addr = scan_idx[7:0];
    assign node_addr = scan_idx[6:0];
    assign scan_fin  = scan_en && (scan_idx == `HUFF_SCAN_LAST);

    always_comb begin
        cand_id.is_node = scan_idx[8];
        cand_id.index   = scan_idx[7:0];  // bit 7 stays clear over the node range.
        cand_val        = scan_idx[8] ? node_weight : leaf_count;
    end

    always_comb begin
        live.first      = id1;
        live.second     = id2;
        live.first_val  = val1;
        live.second_val = val2;
        if (val1 != CNT_NONE && val2 != CNT_NONE) begin
            live.sum = val1 + val2;
        end else begin
            live.sum = '0;
        end
    end

    // the live pair is valid on scan_fin, the held copy afterwards.
    assign least = scan_fin ? live : held;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_idx <= '0;
            id1      <= '0;
            id2      <= '0;
            val1     <= CNT_NONE;
            val2     <= CNT_NONE;
            held     <= '{first: '0, second: '0, first_val: CNT_NONE,
                          second_val: CNT_NONE, sum: '0};
        end else if (scan_en) begin
            if (scan_fin) begin
                scan_idx <= '0;
                id1      <= '0;
                id2      <= '0;
                val1     <= CNT_NONE;
                val2     <= CNT_NONE;
                held     <= live;
            end else begin
                scan_idx <= scan_idx + 9'd1;
                // strict compares keep the earlier index on a tie.
                if (cand_val != '0) begin
                    if (cand_val < val1) begin
                        id2  <= id1;
                        val2 <= val1;
                        id1  <= cand_id;
                        val1 <= cand_val;
                    end else if (cand_val < val2) begin
                        id2  <= cand_id;
                        val2 <= cand_val;
                    end
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) scan_fin |=> !scan_fin)
        else $error("scan_fin longer than one cycle");

    // must hold for the merge that follows, not only on scan_fin.
    assert property (@(posedge clk) disable iff (rst)
        least.first_val <= least.second_val)
        else $error("least pair out of order");

endmodule

`default_nettype wire

// ==== rtl/huff_histogram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "huff_defines.svh"

module huff_histogram import huff_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            clear,
    input  wire            count_en,
    input  wire            byte_valid,
    input  wire [7:0]      byte_data,
    input  wire [7:0]      leaf_addr,
    input  wire            wipe_en,
    input  wire node_id_t  wipe_a,
    input  wire node_id_t  wipe_b,
    output huff_cnt_t      leaf_count
);

    // a count stops one short of the sentinel.
    localparam huff_cnt_t CNT_MAX = CNT_NONE - 1'b1;

    huff_cnt_t cnt [`HUFF_SYMBOLS];
    logic      bump;

    assign bump = count_en && byte_valid && (cnt[byte_data] != CNT_MAX);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `HUFF_SYMBOLS; i++) begin
                cnt[i] <= '0;
            end
        end else if (clear) begin
            for (int i = 0; i < `HUFF_SYMBOLS; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            if (bump) begin
                cnt[byte_data] <= cnt[byte_data] + 1'b1;
            end
            // leaves consumed by a merge drop out of later scans.
            if (wipe_en && !wipe_a.is_node) begin
                cnt[wipe_a.index] <= '0;
            end
            if (wipe_en && !wipe_b.is_node) begin
                cnt[wipe_b.index] <= '0;
            end
        end
    end

    assign leaf_count = cnt[leaf_addr];  // same-cycle answer to the finder.

    // counting happens in idle only, merging never does.
    assert property (@(posedge clk) disable iff (rst)
        !(byte_valid && count_en && wipe_en))
        else $error("byte counted in a merge cycle");

endmodule

`default_nettype wire

// ==== rtl/huff_pkg.sv ====
`default_nettype none

`include "huff_defines.svh"

package huff_pkg;

    // zero marks an empty or consumed entry.
    typedef logic [`HUFF_CNT_W-1:0] huff_cnt_t;

    // "none found" value of a scan.
    localparam huff_cnt_t CNT_NONE = '1;

    typedef struct packed {
        logic       is_node;  // 1 = internal node, 0 = leaf.
        logic [7:0] index;    // byte value or node slot.
    } node_id_t;

    // result of one full scan.
    typedef struct packed {
        node_id_t  first;
        node_id_t  second;
        huff_cnt_t first_val;
        huff_cnt_t second_val;
        huff_cnt_t sum;
    } least_pair_t;

    typedef struct packed {
        node_id_t  left;
        node_id_t  right;
        huff_cnt_t weight;
    } tree_node_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SCAN,
        ST_MERGE,
        ST_DONE
    } build_state_e;

endpackage

`default_nettype wire

// ==== rtl/huff_defines.svh ====
`ifndef HUFF_DEFINES_SVH
`define HUFF_DEFINES_SVH

// leaf symbols, one per byte value.
`define HUFF_SYMBOLS 256

// internal node slots; a full tree would need 255.
`define HUFF_NODES 128

`define HUFF_CNT_W 64

// last scan index, HUFF_SYMBOLS + HUFF_NODES.
`define HUFF_SCAN_LAST 384

`endif
